// File: source/uart_link_settings.svh
`ifndef UART_LINK_SETTINGS_SVH
`define UART_LINK_SETTINGS_SVH

// clock cycles per serial bit, 4 or more
`define UART_BIT_CYCLES 16

// idle cycles on tx between the command byte and the data byte of a write
// the sequencer needs at least 3 of them for its own handoff
`define UART_GAP_CYCLES 20

// cycles allowed for the reply start bit once the command frame has ended
`define UART_REPLY_TIMEOUT 400

// APB byte offsets of the three registers
`define UART_ADDR_CMD 4'h0
`define UART_ADDR_STATUS 4'h4
`define UART_ADDR_RDATA 4'h8

`endif

// File: source/uart_link_pkg.sv
package uart_link_pkg;

  // host command as written to CMD, bit 15 down to bit 0
  typedef struct packed {
    logic       wr;
    logic [6:0] addr;
    logic [7:0] data;
  } link_cmd_t;

  // one byte handed to the tx shifter
  typedef struct packed {
    logic [7:0] data;
  } tx_req_t;

  // one frame as seen by the rx sampler
  typedef struct packed {
    logic [7:0] data;
    logic       parity_ok;
    logic       stop_ok;
  } rx_frame_t;

  // outcome of one command, done is a single-cycle pulse
  typedef struct packed {
    logic       done;
    logic [7:0] rdata;
    logic       parity_err;
    logic       frame_err;
    logic       timeout;
  } link_result_t;

  // STATUS register image, zero-extended onto prdata
  typedef struct packed {
    logic busy;
    logic rd_valid;
    logic parity_err;
    logic frame_err;
    logic timeout;
  } link_status_t;

endpackage

// File: source/apb_cmd_port.sv
`include "uart_link_settings.svh"

module apb_cmd_port
  import uart_link_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  logic [3:0]   paddr,
  input  logic [31:0]  pwdata,
  output logic [31:0]  prdata,
  output logic         pready,
  output logic         pslverr,
  output link_cmd_t    cmd,
  output logic         cmd_valid,
  input  logic         cmd_ready,
  input  link_result_t result,
  input  logic         busy
);

  logic         access;
  logic         hit_cmd;
  logic         hit_status;
  logic         hit_rdata;
  logic         cmd_taken;
  logic         last_rd;
  logic         rd_valid_q;
  logic         perr_q;
  logic         ferr_q;
  logic         tout_q;
  logic [7:0]   rdata_q;
  link_status_t status;

  assign access     = psel && penable;
  assign hit_cmd    = (paddr == `UART_ADDR_CMD);
  assign hit_status = (paddr == `UART_ADDR_STATUS);
  assign hit_rdata  = (paddr == `UART_ADDR_RDATA);

  // a CMD write stays in wait states until the sequencer is idle
  assign cmd_valid = access && pwrite && hit_cmd;
  assign cmd       = link_cmd_t'(pwdata[15:0]);
  assign cmd_taken = cmd_valid && cmd_ready;

  assign pready  = access && (!cmd_valid || cmd_ready);
  assign pslverr = access && (!(hit_cmd || hit_status || hit_rdata) ||
                              (pwrite && (hit_status || hit_rdata)));

  assign status = '{busy: busy, rd_valid: rd_valid_q, parity_err: perr_q,
                    frame_err: ferr_q, timeout: tout_q};

  always_comb
  begin
    prdata = '0;
    if (hit_status)
      prdata = {27'd0, status};
    else if (hit_rdata)
      prdata = {24'd0, rdata_q};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      last_rd    <= 1'b0;
      rd_valid_q <= 1'b0;
      perr_q     <= 1'b0;
      ferr_q     <= 1'b0;
      tout_q     <= 1'b0;
      rdata_q    <= '0;
    end
    else
    begin
      if (cmd_taken)
      begin
        last_rd <= !cmd.wr;
        perr_q  <= 1'b0;
        ferr_q  <= 1'b0;
        tout_q  <= 1'b0;
      end
      if (result.done)
      begin
        perr_q <= result.parity_err;
        ferr_q <= result.frame_err;
        tout_q <= result.timeout;
        if (last_rd)
        begin
          rdata_q    <= result.rdata;
          rd_valid_q <= 1'b1;
        end
      end
      else if (access && !pwrite && hit_rdata)
        rd_valid_q <= 1'b0;
    end
  end

  // the host must hold the transfer while it is stalled
  assert property (@(posedge clk) disable iff (!rst_n)
    (psel && !pready) |=> ($stable(paddr) && $stable(pwrite)));

  // a command is only offered in the access phase that follows its own CMD setup phase
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_valid) |-> $past(psel && !penable && pwrite && paddr == `UART_ADDR_CMD));

endmodule

// File: source/frame_sequencer.sv
`include "uart_link_settings.svh"

module frame_sequencer
  import uart_link_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  link_cmd_t    cmd,
  input  logic         cmd_valid,
  output logic         cmd_ready,
  output tx_req_t      tx_byte,
  output logic         tx_valid,
  input  logic         tx_ready,
  input  rx_frame_t    rx_frame,
  input  logic         rx_valid,
  output link_result_t result,
  output logic         busy
);

  // three idle cycles come from the handoff between sequencer and shifter
  localparam int GAP_LAST  = `UART_GAP_CYCLES - 3;
  // rx_valid lands about ten bits after the start edge, so allow a frame on top
  localparam int WAIT_LAST = `UART_REPLY_TIMEOUT + 11 * `UART_BIT_CYCLES;
  localparam int CNT_W     = $clog2(WAIT_LAST + `UART_GAP_CYCLES + 1);

  typedef enum logic [2:0] {S_IDLE, S_CMD, S_GAP, S_DATA, S_WAIT, S_DONE} state_t;

  state_t           state;
  state_t           state_nx;
  logic             sent;
  logic             tx_done;
  logic [CNT_W-1:0] cnt;
  link_cmd_t        cmd_q;
  logic [7:0]       rdata_q;
  logic             perr_q;
  logic             ferr_q;
  logic             tout_q;

  assign tx_done  = sent && tx_ready;
  assign tx_valid = (state == S_CMD || state == S_DATA) && !sent;
  assign tx_byte  = '{data: (state == S_DATA) ? cmd_q.data : {cmd_q.wr, cmd_q.addr}};
  assign busy     = (state != S_IDLE);
  assign result   = '{done: state == S_DONE, rdata: rdata_q, parity_err: perr_q,
                      frame_err: ferr_q, timeout: tout_q};

  always_comb
  begin
    state_nx = state;
    case (state)
      S_IDLE: if (cmd_valid && cmd_ready) state_nx = S_CMD;
      S_CMD:  if (tx_done) state_nx = cmd_q.wr ? S_GAP : S_WAIT;
      S_GAP:  if (cnt == CNT_W'(GAP_LAST)) state_nx = S_DATA;
      S_DATA: if (tx_done) state_nx = S_DONE;
      S_WAIT: if (rx_valid || cnt == CNT_W'(WAIT_LAST)) state_nx = S_DONE;
      S_DONE: state_nx = S_IDLE;
      default: state_nx = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      cmd_ready <= 1'b0;
      sent      <= 1'b0;
      cnt       <= '0;
      perr_q    <= 1'b0;
      ferr_q    <= 1'b0;
      tout_q    <= 1'b0;
    end
    else
    begin
      state     <= state_nx;
      cmd_ready <= (state_nx == S_IDLE);
      if (state_nx != state)
        cnt <= '0;
      else if (state == S_GAP || state == S_WAIT)
        cnt <= cnt + 1'b1;
      if (tx_valid && tx_ready)
        sent <= 1'b1;
      else if (tx_done)
        sent <= 1'b0;
      if (state == S_IDLE && cmd_valid && cmd_ready)
      begin
        perr_q <= 1'b0;
        ferr_q <= 1'b0;
        tout_q <= 1'b0;
      end
      else if (state == S_WAIT)
      begin
        if (rx_valid)
        begin
          perr_q <= !rx_frame.parity_ok;
          ferr_q <= !rx_frame.stop_ok;
        end
        else if (cnt == CNT_W'(WAIT_LAST))
          tout_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && cmd_valid && cmd_ready)
    begin
      cmd_q   <= cmd;
      rdata_q <= '0;
    end
    else if (state == S_WAIT && rx_valid)
      rdata_q <= rx_frame.data;
  end

  // while a reply is awaited no byte is in flight and the shifter is idle
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_WAIT) |-> (tx_ready && !sent));

endmodule

// File: source/uart_tx_shifter.sv
`include "uart_link_settings.svh"

module uart_tx_shifter
  import uart_link_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  tx_req_t tx_byte,
  input  logic    tx_valid,
  output logic    tx_ready,
  output logic    tx
);

  localparam int BIT = `UART_BIT_CYCLES;
  localparam int PW  = $clog2(BIT);

  logic          busy_q;
  logic          tick;
  logic [3:0]    bit_cnt;
  logic [PW-1:0] per_cnt;
  // data LSB first, then parity, then stop
  logic [9:0]    shreg;

  assign tx_ready = !busy_q;
  assign tick     = (per_cnt == PW'(BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q  <= 1'b0;
      bit_cnt <= '0;
      per_cnt <= '0;
      tx      <= 1'b1;
    end
    else if (!busy_q)
    begin
      if (tx_valid)
      begin
        busy_q  <= 1'b1;
        bit_cnt <= '0;
        per_cnt <= '0;
        tx      <= 1'b0;
      end
    end
    else if (tick)
    begin
      per_cnt <= '0;
      if (bit_cnt == 4'd10)
      begin
        busy_q <= 1'b0;
        tx     <= 1'b1;
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
        tx      <= shreg[0];
      end
    end
    else
      per_cnt <= per_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!busy_q && tx_valid)
      shreg <= {1'b1, ~^tx_byte.data, tx_byte.data};
    else if (busy_q && tick)
      shreg <= {1'b1, shreg[9:1]};
  end

  assert property (@(posedge clk) disable iff (!rst_n) tx_ready |-> tx);

endmodule

// File: source/uart_rx_sampler.sv
`include "uart_link_settings.svh"

module uart_rx_sampler
  import uart_link_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      rx,
  output rx_frame_t rx_frame,
  output logic      rx_valid
);

  localparam int BIT  = `UART_BIT_CYCLES;
  localparam int HALF = BIT / 2;
  localparam int PW   = $clog2(BIT);

  logic [1:0]    sync_q;
  logic          rx_s;
  logic          rx_prev;
  logic          active;
  logic          sample;
  logic [3:0]    bit_cnt;
  logic [PW-1:0] per_cnt;
  logic [7:0]    shreg;
  logic          par_q;

  assign rx_s = sync_q[1];

  // the start bit is rechecked at half a period, every later bit one period on
  assign sample = active && ((bit_cnt == 4'd0) ? (per_cnt == PW'(HALF - 1))
                                               : (per_cnt == PW'(BIT - 1)));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q   <= 2'b11;
      rx_prev  <= 1'b1;
      active   <= 1'b0;
      bit_cnt  <= '0;
      per_cnt  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      sync_q   <= {sync_q[0], rx};
      rx_prev  <= rx_s;
      rx_valid <= 1'b0;
      if (!active)
      begin
        if (rx_prev && !rx_s)
        begin
          active  <= 1'b1;
          bit_cnt <= '0;
          per_cnt <= '0;
        end
      end
      else if (sample)
      begin
        per_cnt <= '0;
        // a glitch that is high again at mid start bit is dropped
        if (bit_cnt == 4'd0 && rx_s)
          active <= 1'b0;
        else if (bit_cnt == 4'd10)
        begin
          active   <= 1'b0;
          rx_valid <= 1'b1;
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
      else
        per_cnt <= per_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
        shreg <= {rx_s, shreg[7:1]};
      else if (bit_cnt == 4'd9)
        par_q <= rx_s;
      else if (bit_cnt == 4'd10)
        rx_frame <= '{data: shreg, parity_ok: (par_q == ~^shreg), stop_ok: rx_s};
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid);

endmodule

// File: source/uart_link_top.sv
module uart_link_top
  import uart_link_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        rx,
  output logic        tx
);

  link_cmd_t    cmd;
  logic         cmd_valid;
  logic         cmd_ready;
  link_result_t result;
  logic         busy;
  tx_req_t      tx_byte;
  logic         tx_valid;
  logic         tx_ready;
  rx_frame_t    rx_frame;
  logic         rx_valid;

  apb_cmd_port u_apb_cmd_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .result    (result),
    .busy      (busy)
  );

  frame_sequencer u_frame_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rx_frame  (rx_frame),
    .rx_valid  (rx_valid),
    .result    (result),
    .busy      (busy)
  );

  uart_tx_shifter u_uart_tx_shifter (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

  uart_rx_sampler u_uart_rx_sampler (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_frame (rx_frame),
    .rx_valid (rx_valid)
  );

endmodule

// File: test/tb_uart_link.sv
`include "uart_link_settings.svh"

module tb_uart_link
  import uart_link_pkg::*;
();

  localparam int BIT        = `UART_BIT_CYCLES;
  localparam int GAP        = `UART_GAP_CYCLES;
  localparam int WRITE_SPAN = 22 * BIT + GAP;
  localparam int POLL_LIMIT = `UART_REPLY_TIMEOUT + 30 * BIT + GAP;
  localparam int RUN_LIMIT  = 400000;

  localparam logic [1:0] REPLY_OK         = 2'd0;
  localparam logic [1:0] REPLY_BAD_PARITY = 2'd1;
  localparam logic [1:0] REPLY_LOW_STOP   = 2'd2;
  localparam logic [1:0] REPLY_WITHHELD   = 2'd3;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        rx;
  logic        tx;

  logic [31:0] lfsr_state;
  int          cycle = 0;
  int          frames_seen = 0;
  logic [7:0]  remote_mem [128];
  logic [7:0]  ref_mem [128];
  link_cmd_t   seen_cmds [$];
  logic [6:0]  written [$];
  logic        reply_pending;
  logic [6:0]  reply_addr;
  logic [1:0]  reply_mode;
  int          reply_delay;

  uart_link_top uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rx      (rx),
    .tx      (tx)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [7:0] fill_byte(input logic [6:0] addr);
    return {addr, ~addr[0]} ^ 8'ha5;
  endfunction

  function automatic link_status_t make_status(input logic busy, input logic rd_valid,
                                               input logic perr, input logic ferr,
                                               input logic tout);
    link_status_t s;
    s.busy       = busy;
    s.rd_valid   = rd_valid;
    s.parity_err = perr;
    s.frame_err  = ferr;
    s.timeout    = tout;
    return s;
  endfunction

  task automatic report_failure(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_cmd(input link_cmd_t got, input link_cmd_t exp, input string what);
    if (got !== exp)
      report_failure($sformatf("%s: command %h, expected %h", what, got, exp));
  endtask

  task automatic compare_status(input link_status_t got, input link_status_t exp,
                                input string what);
    if (got !== exp)
      report_failure($sformatf("%s: status %b, expected %b", what, got, exp));
  endtask

  task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
      report_failure($sformatf("%s: byte %h, expected %h", what, got, exp));
  endtask

  task automatic compare_resp(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_failure($sformatf("%s: pslverr %b, expected %b", what, got, exp));
  endtask

  // one APB transfer, setup on one falling edge and access on the next
  task automatic apb_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err, output int waits);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    @(posedge clk);
    while (pready !== 1'b1)
    begin
      if (waits > POLL_LIMIT)
        report_failure("APB transfer never saw pready");
      else
      begin
        waits++;
        @(posedge clk);
      end
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_status(output link_status_t st);
    logic [31:0] rd;
    logic        err;
    int          waits;
    apb_transfer(1'b0, `UART_ADDR_STATUS, '0, rd, err, waits);
    st = link_status_t'(rd[4:0]);
    compare_resp(err, 1'b0, "STATUS read");
    if (rd[31:5] !== '0)
      report_failure("STATUS read carries bits above the status field");
  endtask

  task automatic wait_until_idle(output link_status_t st);
    int polls;
    polls = 0;
    read_status(st);
    while (st.busy)
    begin
      if (polls > POLL_LIMIT)
        report_failure("busy never cleared in STATUS");
      else
      begin
        polls++;
        read_status(st);
      end
    end
  endtask

  // a new command must show busy at once with every flag cleared
  task automatic issue_command(input link_cmd_t c);
    logic [31:0]  rd;
    logic         err;
    int           waits;
    link_status_t st;
    apb_transfer(1'b1, `UART_ADDR_CMD, {16'h0, c}, rd, err, waits);
    compare_resp(err, 1'b0, "CMD write");
    read_status(st);
    compare_status(st, make_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "STATUS after a command");
  endtask

  task automatic check_decoded(input link_cmd_t c);
    if (seen_cmds.size() == 0)
      report_failure("no command was decoded on tx");
    else
      compare_cmd(seen_cmds.pop_front(), c, "command decoded on tx");
  endtask

  task automatic do_write(input logic [6:0] addr, input logic [7:0] data);
    link_cmd_t    c;
    link_status_t st;
    c.wr   = 1'b1;
    c.addr = addr;
    c.data = data;
    issue_command(c);
    wait_until_idle(st);
    compare_status(st, make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), "STATUS after a write");
    check_decoded(c);
    compare_byte(remote_mem[addr], data, "remote register after a write");
    ref_mem[addr] = data;
    written.push_back(addr);
  endtask

  task automatic do_read(input logic [6:0] addr, input logic [1:0] mode);
    link_cmd_t    c;
    link_status_t st;
    link_status_t exp_st;
    logic [31:0]  dly;
    logic [31:0]  rd;
    logic         err;
    int           waits;
    logic [7:0]   exp_data;
    draw_bits(6, dly);
    reply_mode  = mode;
    reply_delay = BIT + int'(dly);
    c.wr   = 1'b0;
    c.addr = addr;
    c.data = 8'h00;
    issue_command(c);
    wait_until_idle(st);
    exp_st = make_status(1'b0, 1'b1, mode == REPLY_BAD_PARITY, mode == REPLY_LOW_STOP,
                         mode == REPLY_WITHHELD);
    compare_status(st, exp_st, "STATUS after a read");
    exp_data = (mode == REPLY_WITHHELD) ? 8'h00 : ref_mem[addr];
    apb_transfer(1'b0, `UART_ADDR_RDATA, '0, rd, err, waits);
    compare_resp(err, 1'b0, "RDATA read");
    compare_byte(rd[7:0], exp_data, "RDATA");
    if (rd[31:8] !== '0)
      report_failure("RDATA read carries bits above the data byte");
    read_status(st);
    exp_st.rd_valid = 1'b0;
    compare_status(st, exp_st, "STATUS after reading RDATA");
    check_decoded(c);
  endtask

  task automatic back_pressure();
    link_cmd_t    first;
    link_cmd_t    second;
    logic [31:0]  r;
    logic [31:0]  rd;
    logic         err;
    int           waits;
    link_status_t st;
    draw_bits(15, r);
    first.wr   = 1'b1;
    first.addr = r[14:8];
    first.data = r[7:0];
    draw_bits(8, r);
    second.wr   = 1'b1;
    second.addr = ~first.addr;
    second.data = r[7:0];
    apb_transfer(1'b1, `UART_ADDR_CMD, {16'h0, first}, rd, err, waits);
    compare_resp(err, 1'b0, "first CMD write");
    apb_transfer(1'b1, `UART_ADDR_CMD, {16'h0, second}, rd, err, waits);
    compare_resp(err, 1'b0, "held CMD write");
    if (waits < WRITE_SPAN)
      report_failure("a command written while busy was not held until the bridge was idle");
    else if (waits > WRITE_SPAN + 6)
      report_failure("a held command waited well past the end of the first transaction");
    wait_until_idle(st);
    compare_status(st, make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), "STATUS after two writes");
    if (seen_cmds.size() != 2)
      report_failure("back-to-back writes did not give two decoded commands");
    check_decoded(first);
    check_decoded(second);
    compare_byte(remote_mem[first.addr], first.data, "remote register of the first write");
    compare_byte(remote_mem[second.addr], second.data, "remote register of the held write");
    ref_mem[first.addr]  = first.data;
    ref_mem[second.addr] = second.data;
  endtask

  task automatic expect_slverr(input logic wr, input logic [3:0] addr, input string what);
    logic [31:0] rd;
    logic        err;
    int          waits;
    apb_transfer(wr, addr, 32'h0000_80ff, rd, err, waits);
    compare_resp(err, 1'b1, what);
    if (waits != 0)
      report_failure("a rejected access took wait states");
  endtask

  // waits for one frame on tx and returns at the middle of its stop bit
  task automatic receive_frame(input int limit, output logic found, output logic [7:0] data,
                               output int start);
    int   idle;
    logic par;
    found = 1'b0;
    idle  = 0;
    data  = '0;
    start = 0;
    while (!found && idle < limit)
    begin
      @(negedge clk);
      if (tx === 1'b0)
        found = 1'b1;
      else
        idle++;
    end
    if (found)
    begin
      start = cycle;
      frames_seen++;
      repeat (BIT / 2) @(negedge clk);
      if (tx !== 1'b0)
        report_failure("start bit on tx ended before mid-bit");
      for (int i = 0; i < 8; i++)
      begin
        repeat (BIT) @(negedge clk);
        data[i] = tx;
      end
      repeat (BIT) @(negedge clk);
      par = tx;
      repeat (BIT) @(negedge clk);
      if (par !== ~^data)
        report_failure("frame on tx has a wrong parity bit");
      else if (tx !== 1'b1)
        report_failure("frame on tx has a low stop bit");
    end
  endtask

  task automatic send_frame(input logic [7:0] data, input logic par, input logic stop);
    logic [10:0] bits;
    bits = {stop, par, data, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx = bits[i];
      repeat (BIT) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  // remote device, decodes every frame the bridge sends
  initial
  begin : remote_model
    logic       found;
    logic [7:0] cmd_byte;
    logic [7:0] data_byte;
    int         cmd_start;
    int         data_start;
    link_cmd_t  decoded;
    forever
    begin
      receive_frame(RUN_LIMIT, found, cmd_byte, cmd_start);
      if (found && cmd_byte[7])
      begin
        receive_frame(GAP + 2 * BIT, found, data_byte, data_start);
        if (!found)
          report_failure("data byte of a write never followed its command byte");
        else if (data_start - cmd_start < 11 * BIT + GAP)
          report_failure("write frames on tx are closer than the inter-frame gap");
        else
        begin
          remote_mem[cmd_byte[6:0]] = data_byte;
          decoded = {cmd_byte, data_byte};
          seen_cmds.push_back(decoded);
        end
      end
      else if (found)
      begin
        decoded = {cmd_byte, 8'h00};
        seen_cmds.push_back(decoded);
        reply_addr    = cmd_byte[6:0];
        reply_pending = 1'b1;
      end
    end
  end

  // answers a read on rx, possibly damaged or not at all
  initial
  begin : reply_driver
    logic [7:0] data;
    logic       par;
    logic       stop;
    logic [1:0] mode;
    forever
    begin
      @(posedge clk);
      if (reply_pending)
      begin
        reply_pending = 1'b0;
        mode = reply_mode;
        data = remote_mem[reply_addr];
        par  = (~^data) ^ (mode == REPLY_BAD_PARITY);
        stop = (mode != REPLY_LOW_STOP);
        repeat (reply_delay) @(negedge clk);
        if (mode != REPLY_WITHHELD)
          send_frame(data, par, stop);
      end
    end
  end

  initial
  begin : watchdog
    repeat (RUN_LIMIT) @(posedge clk);
    report_failure("simulation ran past its cycle limit");
  end

  initial
  begin : stimulus
    link_status_t st;
    logic [31:0]  r;
    int           frames_before;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    rx            = 1'b1;
    rst_n         = 1'b0;
    lfsr_state    = 32'h34cc;
    reply_pending = 1'b0;
    reply_addr    = '0;
    reply_mode    = REPLY_OK;
    reply_delay   = 0;
    for (int i = 0; i < 128; i++)
    begin
      remote_mem[i] = fill_byte(7'(i));
      ref_mem[i]    = fill_byte(7'(i));
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    if (tx !== 1'b1)
      report_failure("tx is not high after reset");
    read_status(st);
    compare_status(st, make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), "STATUS after reset");

    for (int k = 0; k < 12; k++)
    begin
      draw_bits(15, r);
      do_write(r[14:8], r[7:0]);
    end

    for (int k = 0; k < 8; k++)
    begin
      draw_bits(5, r);
      do_read(written[r % written.size()], REPLY_OK);
    end

    // each damaged reply once, then a random mix
    do_read(written[0], REPLY_BAD_PARITY);
    do_read(written[1], REPLY_LOW_STOP);
    do_read(written[2], REPLY_WITHHELD);
    for (int k = 0; k < 6; k++)
    begin
      draw_bits(7, r);
      do_read(written[r[6:2] % written.size()], r[1:0]);
    end
    draw_bits(15, r);
    do_write(r[14:8], r[7:0]);

    back_pressure();

    frames_before = frames_seen;
    expect_slverr(1'b0, 4'hc, "read of an unmapped offset");
    expect_slverr(1'b1, 4'h2, "write to an unmapped offset");
    expect_slverr(1'b1, `UART_ADDR_STATUS, "write to STATUS");
    expect_slverr(1'b1, `UART_ADDR_RDATA, "write to RDATA");
    repeat (11 * BIT + GAP) @(negedge clk);
    if (frames_seen != frames_before)
      report_failure("a rejected access put a frame on tx");
    read_status(st);
    compare_status(st, make_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0),
                   "STATUS after rejected accesses");

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+source
source/uart_link_pkg.sv
source/apb_cmd_port.sv
source/frame_sequencer.sv
source/uart_tx_shifter.sv
source/uart_rx_sampler.sv
source/uart_link_top.sv
test/tb_uart_link.sv
